/* compile.f */
bus_pkg.sv
panel_pkg.sv
master_if.sv
key_timer.sv
panel_fsm.sv
write_master.sv
read_master.sv
word_ram.sv
hex_display.sv
dma_panel_top.sv
tb_dma_panel.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_dma_panel
FILELIST = compile.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)

run: compile
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_dma_panel.sv */
`timescale 1ns/100ps
`default_nettype none

module tb_dma_panel;

	localparam int NUM_TESTS = 5;
	localparam int CYCLES_PER_TEST = 400;
	localparam int WAIT_LIMIT = 200;  // cycles per operation
	localparam int HOLD_CYCLES = 20;  // key held low
	localparam int LED_RD_DONE = 1;
	localparam int LED_WR_DONE = 6;

	// active low digit patterns 0 to F
	localparam logic [6:0] SEG_CODES [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

	logic CLOCK_50 = 1'b0;
	logic arst_n;
	logic [17:0] sw;
	logic [3:0] key;
	logic [8:0] ledg;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic [6:0] hex4;
	logic [6:0] hex5;
	logic [6:0] hex6;
	logic [6:0] hex7;

	dma_panel_top dma_panel_top_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.sw(sw),
		.key(key),
		.ledg(ledg),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.hex6(hex6),
		.hex7(hex7)
	);

	always #2 CLOCK_50 = ~CLOCK_50;  // 4 ns period

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			stop_run($sformatf("error: %s got %h expected %h", name, got, exp));
		end
	endtask

	// top byte is the seed, low 24 bits the word index
	function automatic logic [31:0] block_word(input logic [6:0] seed, input int idx);
		return {1'b0, seed, 24'(idx)};
	endfunction

	function automatic logic [31:0] panel_value(input logic [6:0] seed, input logic [7:0] addr);
		return {16'h0000, 1'b0, seed, addr};
	endfunction

	function automatic logic [17:0] switch_word(input logic rdwr, input logic disp,
		input logic fixed, input logic [6:0] seed, input logic [7:0] addr);
		return {rdwr, disp, fixed, seed, addr};
	endfunction

	task automatic decode_digit(input logic [6:0] seg, output logic [3:0] nib);
		int found;
		found = -1;
		for (int n = 0; n < 16; n++) begin
			if (SEG_CODES[n] == seg) found = n;
		end
		if (found < 0) begin
			stop_run($sformatf("a display digit shows no hex pattern (%b)", seg));
		end
		nib = 4'(found);
	endtask

	task automatic read_display(output logic [31:0] value);
		logic [6:0] segs [8];
		logic [3:0] nib;
		segs = '{hex0, hex1, hex2, hex3, hex4, hex5, hex6, hex7};
		value = '0;
		for (int d = 0; d < 8; d++) begin
			decode_digit(segs[d], nib);
			value[d*4 +: 4] = nib;  // hex0 is the bottom nibble
		end
	endtask

	task automatic reset_dut();
		@(negedge CLOCK_50);
		arst_n = 1'b0;
		repeat (10) @(negedge CLOCK_50);
		arst_n = 1'b1;
		@(negedge CLOCK_50);
	endtask

	task automatic press_key();
		key[1] = 1'b0;
		repeat (HOLD_CYCLES) @(negedge CLOCK_50);
		key[1] = 1'b1;
	endtask

	// reset, set switches, press, wait for the done LED
	task automatic run_op(input logic [17:0] switches, input int done_bit);
		int waited;
		waited = 0;
		sw = switches;
		reset_dut();
		press_key();
		while (!ledg[done_bit] && waited < WAIT_LIMIT) begin
			@(negedge CLOCK_50);
			waited++;
		end
		if (!ledg[done_bit]) begin
			stop_run("an operation did not finish within the wait limit");
		end
		repeat (2) @(negedge CLOCK_50);  // let the read word settle
	endtask

	task automatic write_block(input logic [6:0] seed, input logic [7:0] addr, input logic fixed);
		run_op(switch_word(1'b0, 1'b0, fixed, seed, addr), LED_WR_DONE);
	endtask

	task automatic read_expect(input logic [7:0] addr, input logic [31:0] exp);
		logic [31:0] shown;
		run_op(switch_word(1'b1, 1'b1, 1'b0, 7'h00, addr), LED_RD_DONE);
		read_display(shown);
		check("display", shown, exp);
	endtask

	task automatic reset_values();
		logic [6:0] seed;
		logic [7:0] addr;
		logic [31:0] shown;
		seed = 7'($urandom);
		addr = 8'($urandom);
		sw = switch_word(1'b0, 1'b0, 1'b0, seed, addr);
		reset_dut();
		check("ledg", 32'(ledg), 32'h0);
		read_display(shown);
		check("display", shown, panel_value(seed, addr));
	endtask

	task automatic write_read_back();
		logic [6:0] seed;
		logic [7:0] bases [2];
		bases = '{8'($urandom), 8'hfe};  // second block wraps past 255
		foreach (bases[b]) begin
			seed = 7'($urandom);
			write_block(seed, bases[b], 1'b0);
			for (int i = 0; i < 4; i++) begin
				read_expect(bases[b] + 8'(i), block_word(seed, i));
			end
		end
	endtask

	task automatic fixed_location_overwrite();
		logic [6:0] old_seed;
		logic [6:0] new_seed;
		logic [7:0] addr;
		old_seed = 7'($urandom);
		new_seed = ~old_seed;  // always differs
		addr = 8'($urandom);
		write_block(old_seed, addr, 1'b0);
		write_block(new_seed, addr, 1'b1);
		read_expect(addr, block_word(new_seed, 3));
		read_expect(addr + 8'd1, block_word(old_seed, 1));
	endtask

	task automatic led_flag_pattern();
		logic [7:0] addr;
		addr = 8'($urandom);
		write_block(7'($urandom), addr, 1'b0);
		check("ledg", 32'(ledg), 32'h0c0);
		run_op(switch_word(1'b1, 1'b1, 1'b0, 7'h00, addr), LED_RD_DONE);
		check("ledg", 32'(ledg), 32'h007);
	endtask

	task automatic display_toggle();
		logic [6:0] seed;
		logic [7:0] addr;
		logic [31:0] shown;
		seed = 7'($urandom);
		addr = 8'($urandom);
		write_block(seed, addr, 1'b0);
		run_op(switch_word(1'b1, 1'b1, 1'b0, seed, addr), LED_RD_DONE);
		for (int n = 0; n < 2; n++) begin
			sw[panel_pkg::SW_DISP_SEL] = 1'b0;
			repeat (3) @(negedge CLOCK_50);
			read_display(shown);
			check("display", shown, panel_value(seed, addr));
			sw[panel_pkg::SW_DISP_SEL] = 1'b1;
			repeat (3) @(negedge CLOCK_50);
			read_display(shown);
			check("display", shown, block_word(seed, 0));
		end
		check("ledg", 32'(ledg), 32'h007);  // no new operation
	endtask

	initial begin
		repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge CLOCK_50);
		stop_run("watchdog expired before the tests finished");
	end

	initial begin
		void'($urandom(32'hed6c889f));
		arst_n = 1'b0;
		sw = '0;
		key = 4'hf;  // keys idle high
		reset_values();
		write_read_back();
		fixed_location_overwrite();
		led_flag_pattern();
		display_toggle();
		$display("TEST PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* dma_panel_top.sv */
`timescale 1ns/100ps
`default_nettype none

module dma_panel_top (
	input logic CLOCK_50,
	input logic arst_n,
	input logic [17:0] sw,
	input logic [3:0] key,
	output logic [8:0] ledg,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [6:0] hex6,
	output logic [6:0] hex7
);

	master_ctl_if wr_ctl ();
	master_ctl_if rd_ctl ();
	rd_mem_if rd_mem ();

	logic press;
	logic wr_push;
	logic wr_full;
	bus_pkg::word_t wr_word;
	logic rd_pop;
	logic rd_avail;
	bus_pkg::word_t rd_word;
	logic ram_write;
	logic [bus_pkg::RAM_AW-1:0] ram_addr;
	bus_pkg::word_t ram_wdata;
	bus_pkg::word_t display_word;

	key_timer key_timer_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.key_n(key[1]),  // action key
		.press(press)
	);

	panel_fsm panel_fsm_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.press(press),
		.sw(sw),
		.wr_ctl(wr_ctl),
		.rd_ctl(rd_ctl),
		.write_buffer(wr_push),
		.wr_data(wr_word),
		.buffer_full(wr_full),
		.read_buffer(rd_pop),
		.rd_data(rd_word),
		.data_available(rd_avail),
		.ledg(ledg),
		.display_word(display_word)
	);

	write_master write_master_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.ctl(wr_ctl),
		.write_buffer(wr_push),
		.buffer_data(wr_word),
		.buffer_full(wr_full),
		.ram_write(ram_write),
		.ram_addr(ram_addr),
		.ram_wdata(ram_wdata)
	);

	read_master read_master_inst (
		.CLOCK_50(CLOCK_50),
		.arst_n(arst_n),
		.ctl(rd_ctl),
		.mem(rd_mem),
		.read_buffer(rd_pop),
		.buffer_data(rd_word),
		.data_available(rd_avail)
	);

	word_ram word_ram_inst (
		.CLOCK_50(CLOCK_50),
		.write(ram_write),
		.waddr(ram_addr),
		.wdata(ram_wdata),
		.mem(rd_mem)
	);

	hex_display hex_display_inst (
		.value(display_word),
		.hex0(hex0),
		.hex1(hex1),
		.hex2(hex2),
		.hex3(hex3),
		.hex4(hex4),
		.hex5(hex5),
		.hex6(hex6),
		.hex7(hex7)
	);

endmodule

`default_nettype wire

/* hex_display.sv */
`timescale 1ns/100ps
`default_nettype none

module hex_display (
	input bus_pkg::word_t value,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic [6:0] hex4,
	output logic [6:0] hex5,
	output logic [6:0] hex6,
	output logic [6:0] hex7
);

	assign hex0 = panel_pkg::SEG_TABLE[value[3:0]];  // bottom nibble
	assign hex1 = panel_pkg::SEG_TABLE[value[7:4]];
	assign hex2 = panel_pkg::SEG_TABLE[value[11:8]];
	assign hex3 = panel_pkg::SEG_TABLE[value[15:12]];
	assign hex4 = panel_pkg::SEG_TABLE[value[19:16]];
	assign hex5 = panel_pkg::SEG_TABLE[value[23:20]];
	assign hex6 = panel_pkg::SEG_TABLE[value[27:24]];
	assign hex7 = panel_pkg::SEG_TABLE[value[31:28]];  // top nibble

endmodule

`default_nettype wire

/* word_ram.sv */
`timescale 1ns/100ps
`default_nettype none

module word_ram (
	input logic CLOCK_50,
	input logic write,
	input logic [bus_pkg::RAM_AW-1:0] waddr,
	input bus_pkg::word_t wdata,
	rd_mem_if.ram mem
);

	bus_pkg::word_t words [bus_pkg::RAM_WORDS];

	always_ff @(posedge CLOCK_50) begin
		if (write) begin
			words[waddr] <= wdata;
		end
	end

	// read-before-write on a same-address collision
	always_ff @(posedge CLOCK_50) begin
		mem.readdata <= words[mem.addr];
		mem.readdatavalid <= mem.read;  // fixed one-cycle latency
	end

endmodule

`default_nettype wire

/* read_master.sv */
`timescale 1ns/100ps
`default_nettype none

module read_master (
	input logic CLOCK_50,
	input logic arst_n,
	master_ctl_if.master ctl,
	rd_mem_if.master mem,
	input logic read_buffer,
	output bus_pkg::word_t buffer_data,
	output logic data_available
);

	bus_pkg::word_t fifo [bus_pkg::FIFO_DEPTH];
	logic [bus_pkg::FIFO_AW-1:0] wr_ptr;
	logic [bus_pkg::FIFO_AW-1:0] rd_ptr;
	logic [bus_pkg::FIFO_AW:0] count;
	logic [bus_pkg::FIFO_AW:0] pending;  // reads in flight
	logic pop;
	logic active;
	bus_pkg::addr_t cur_addr;
	bus_pkg::addr_t issue_left;
	bus_pkg::addr_t recv_left;
	logic fixed;

	assign data_available = (count != '0);
	assign buffer_data = fifo[rd_ptr];  // head of fifo
	assign pop = read_buffer && data_available;
	assign mem.read = active && (issue_left != '0) &&
		(int'(count) + int'(pending) < bus_pkg::FIFO_DEPTH);
	assign mem.addr = cur_addr[bus_pkg::RAM_AW+1:2];

	always_ff @(posedge CLOCK_50) begin
		if (mem.readdatavalid) fifo[wr_ptr] <= mem.readdata;
		if (ctl.go) begin
			cur_addr <= ctl.base;
			fixed <= ctl.fixed_location;
		end else if (mem.read && !fixed) begin
			cur_addr <= cur_addr + bus_pkg::addr_t'(4);
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			pending <= '0;
			active <= 1'b0;
			issue_left <= '0;
			recv_left <= '0;
			ctl.done <= 1'b0;
		end else begin
			ctl.done <= 1'b0;
			if (mem.readdatavalid) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({mem.readdatavalid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			case ({mem.read, mem.readdatavalid})
				2'b10: pending <= pending + 1'b1;
				2'b01: pending <= pending - 1'b1;
				default: ;
			endcase
			if (ctl.go) begin
				active <= 1'b1;
				issue_left <= ctl.length >> 2;
				recv_left <= ctl.length >> 2;
			end else begin
				if (mem.read) issue_left <= issue_left - 1'b1;
				if (mem.readdatavalid) begin
					recv_left <= recv_left - 1'b1;
					if (recv_left == bus_pkg::addr_t'(1)) begin
						active <= 1'b0;  // last word now in fifo
						ctl.done <= 1'b1;
					end
				end
			end
		end
	end

	a_no_pop_empty: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		read_buffer |-> data_available)
		else $error("pop from empty read buffer");

endmodule

`default_nettype wire

/* write_master.sv */
`timescale 1ns/100ps
`default_nettype none

module write_master (
	input logic CLOCK_50,
	input logic arst_n,
	master_ctl_if.master ctl,
	input logic write_buffer,
	input bus_pkg::word_t buffer_data,
	output logic buffer_full,
	output logic ram_write,
	output logic [bus_pkg::RAM_AW-1:0] ram_addr,
	output bus_pkg::word_t ram_wdata
);

	bus_pkg::word_t fifo [bus_pkg::FIFO_DEPTH];
	logic [bus_pkg::FIFO_AW-1:0] wr_ptr;
	logic [bus_pkg::FIFO_AW-1:0] rd_ptr;
	logic [bus_pkg::FIFO_AW:0] count;
	logic push;
	logic active;
	logic fixed;
	bus_pkg::addr_t cur_addr;
	bus_pkg::addr_t words_left;

	assign buffer_full = count[bus_pkg::FIFO_AW];  // count reached depth
	assign push = write_buffer && !buffer_full;
	assign ram_write = active && (count != '0);  // one word per cycle
	assign ram_addr = cur_addr[bus_pkg::RAM_AW+1:2];
	assign ram_wdata = fifo[rd_ptr];

	always_ff @(posedge CLOCK_50) begin
		if (push) fifo[wr_ptr] <= buffer_data;
		if (ctl.go) begin
			cur_addr <= ctl.base;
			fixed <= ctl.fixed_location;
		end else if (ram_write && !fixed) begin
			cur_addr <= cur_addr + bus_pkg::addr_t'(4);
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			active <= 1'b0;
			words_left <= '0;
			ctl.done <= 1'b0;
		end else begin
			ctl.done <= 1'b0;
			if (push) wr_ptr <= wr_ptr + 1'b1;
			if (ram_write) rd_ptr <= rd_ptr + 1'b1;
			case ({push, ram_write})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;
			endcase
			if (ctl.go) begin
				active <= 1'b1;
				words_left <= ctl.length >> 2;  // bytes to words
			end else if (ram_write) begin
				words_left <= words_left - 1'b1;
				if (words_left == bus_pkg::addr_t'(1)) begin
					active <= 1'b0;
					ctl.done <= 1'b1;
				end
			end
		end
	end

	a_no_push_full: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		write_buffer |-> !buffer_full)
		else $error("push into full write buffer");

endmodule

`default_nettype wire

/* panel_fsm.sv */
`timescale 1ns/100ps
`default_nettype none

module panel_fsm (
	input logic CLOCK_50,
	input logic arst_n,
	input logic press,
	input logic [17:0] sw,
	master_ctl_if.fsm wr_ctl,
	master_ctl_if.fsm rd_ctl,
	output logic write_buffer,
	output bus_pkg::word_t wr_data,
	input logic buffer_full,
	output logic read_buffer,
	input bus_pkg::word_t rd_data,
	input logic data_available,
	output logic [8:0] ledg,
	output bus_pkg::word_t display_word
);

	panel_pkg::state_t state;
	logic op_fixed;
	logic [panel_pkg::SW_SEED_HI-panel_pkg::SW_SEED_LO:0] op_seed;
	logic [panel_pkg::SW_ADDR_HI-panel_pkg::SW_ADDR_LO:0] op_addr;
	logic [$clog2(bus_pkg::BLOCK_WORDS)-1:0] word_idx;
	bus_pkg::word_t read_word;
	logic wr_open;  // write go seen, done not yet
	logic rd_open;

	assign wr_ctl.go = (state == panel_pkg::WR_GO);
	assign wr_ctl.fixed_location = op_fixed;
	assign wr_ctl.base = bus_pkg::addr_t'({op_addr, 2'b00});
	assign wr_ctl.length = bus_pkg::addr_t'(bus_pkg::BLOCK_WORDS * 4);

	assign rd_ctl.go = (state == panel_pkg::RD_GO);
	assign rd_ctl.fixed_location = 1'b0;  // single word
	assign rd_ctl.base = bus_pkg::addr_t'({op_addr, 2'b00});
	assign rd_ctl.length = bus_pkg::addr_t'(4);

	assign write_buffer = (state == panel_pkg::WR_FILL) && !buffer_full;
	assign wr_data = bus_pkg::word_t'({op_seed, 24'(word_idx)});  // seed byte, index below
	assign read_buffer = (state == panel_pkg::RD_TAKE) && data_available;

	// live switches, so toggling needs no press
	assign display_word = sw[panel_pkg::SW_DISP_SEL] ? read_word :
		bus_pkg::word_t'({sw[panel_pkg::SW_SEED_HI:panel_pkg::SW_SEED_LO],
		sw[panel_pkg::SW_ADDR_HI:panel_pkg::SW_ADDR_LO]});

	always_ff @(posedge CLOCK_50) begin
		if (state == panel_pkg::IDLE && press) begin
			op_fixed <= sw[panel_pkg::SW_FIXED];
			op_seed <= sw[panel_pkg::SW_SEED_HI:panel_pkg::SW_SEED_LO];
			op_addr <= sw[panel_pkg::SW_ADDR_HI:panel_pkg::SW_ADDR_LO];
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			state <= panel_pkg::IDLE;
			word_idx <= '0;
			read_word <= '0;
		end else begin
			case (state)
				panel_pkg::IDLE: begin
					if (press && sw[panel_pkg::SW_RDWR]) begin
						state <= panel_pkg::RD_GO;
					end else if (press) begin
						state <= panel_pkg::WR_GO;
					end
				end
				panel_pkg::WR_GO: begin
					word_idx <= '0;
					state <= panel_pkg::WR_FILL;
				end
				panel_pkg::WR_FILL: begin
					if (write_buffer) begin
						word_idx <= word_idx + 1'b1;
						if (int'(word_idx) == bus_pkg::BLOCK_WORDS - 1) begin
							state <= panel_pkg::WR_WAIT;
						end
					end
				end
				panel_pkg::WR_WAIT: begin
					if (wr_ctl.done) begin
						state <= panel_pkg::IDLE;
					end
				end
				panel_pkg::RD_GO: begin
					state <= panel_pkg::RD_TAKE;
				end
				panel_pkg::RD_TAKE: begin
					if (read_buffer) begin
						read_word <= rd_data;
						// done may come with the first data
						state <= rd_ctl.done ? panel_pkg::IDLE : panel_pkg::RD_WAIT;
					end
				end
				panel_pkg::RD_WAIT: begin
					if (rd_ctl.done) begin
						state <= panel_pkg::IDLE;
					end
				end
				default: begin
					state <= panel_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			ledg <= '0;
			wr_open <= 1'b0;
			rd_open <= 1'b0;
		end else begin
			if (rd_ctl.go) ledg[0] <= 1'b1;
			if (rd_ctl.done) ledg[1] <= 1'b1;
			if (data_available) ledg[2] <= 1'b1;
			if (write_buffer && wr_data == '1) ledg[5] <= 1'b1;
			if (wr_ctl.done) ledg[6] <= 1'b1;
			if (wr_ctl.go) ledg[7] <= 1'b1;
			if (wr_ctl.go) wr_open <= 1'b1;
			else if (wr_ctl.done) wr_open <= 1'b0;
			if (rd_ctl.go) rd_open <= 1'b1;
			else if (rd_ctl.done) rd_open <= 1'b0;
		end
	end

	a_wr_go_after_done: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		wr_ctl.go |-> !wr_open)
		else $error("write go before previous done");

	a_rd_go_after_done: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		rd_ctl.go |-> !rd_open)
		else $error("read go before previous done");

endmodule

`default_nettype wire

/* key_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module key_timer (
	input logic CLOCK_50,
	input logic arst_n,
	input logic key_n,
	output logic press
);

	logic [$clog2(panel_pkg::DEBOUNCE_CYCLES)-1:0] low_cnt;
	logic fired;  // pulse already given for this press

	always_ff @(posedge CLOCK_50 or negedge arst_n) begin
		if (!arst_n) begin
			low_cnt <= '0;
			fired <= 1'b0;
			press <= 1'b0;
		end else begin
			press <= 1'b0;
			if (key_n) begin
				low_cnt <= '0;  // released, rearm
				fired <= 1'b0;
			end else if (!fired) begin
				if (int'(low_cnt) == panel_pkg::DEBOUNCE_CYCLES - 1) begin
					press <= 1'b1;
					fired <= 1'b1;
				end else begin
					low_cnt <= low_cnt + 1'b1;
				end
			end
		end
	end

	a_single_press: assert property (@(posedge CLOCK_50) disable iff (!arst_n)
		press |=> !press)
		else $error("press pulse longer than one cycle");

endmodule

`default_nettype wire

/* master_if.sv */
`timescale 1ns/100ps
`default_nettype none

interface master_ctl_if;
	logic fixed_location;
	bus_pkg::addr_t base;
	bus_pkg::addr_t length;  // in bytes
	logic go;
	logic done;

	modport fsm (output fixed_location, base, length, go, input done);
	modport master (input fixed_location, base, length, go, output done);
endinterface

interface rd_mem_if;
	logic read;
	logic [bus_pkg::RAM_AW-1:0] addr;  // word index
	bus_pkg::word_t readdata;
	logic readdatavalid;  // one cycle after read

	modport master (output read, addr, input readdata, readdatavalid);
	modport ram (input read, addr, output readdata, readdatavalid);
endinterface

`default_nettype wire

/* panel_pkg.sv */
`default_nettype none

package panel_pkg;

	// switch fields
	localparam int SW_RDWR = 17;  // high selects read
	localparam int SW_DISP_SEL = 16;  // high shows last read word
	localparam int SW_FIXED = 15;
	localparam int SW_SEED_HI = 14;
	localparam int SW_SEED_LO = 8;
	localparam int SW_ADDR_HI = 7;
	localparam int SW_ADDR_LO = 0;

	localparam int DEBOUNCE_CYCLES = 16;

	typedef enum logic [2:0] {
		IDLE,
		WR_GO,
		WR_FILL,
		WR_WAIT,
		RD_GO,
		RD_TAKE,
		RD_WAIT
	} state_t;

	// active low, bit 0 is segment a
	localparam logic [6:0] SEG_TABLE [16] = '{
		7'b1000000, 7'b1111001, 7'b0100100, 7'b0110000,
		7'b0011001, 7'b0010010, 7'b0000010, 7'b1111000,
		7'b0000000, 7'b0010000, 7'b0001000, 7'b0000011,
		7'b1000110, 7'b0100001, 7'b0000110, 7'b0001110
	};

endpackage

`default_nettype wire

/* bus_pkg.sv */
`default_nettype none

package bus_pkg;

	localparam int ADDR_W = 28;  // byte address
	localparam int DATA_W = 32;

	localparam int RAM_WORDS = 256;
	localparam int RAM_AW = $clog2(RAM_WORDS);  // word index, byte addr bits 9:2

	localparam int FIFO_DEPTH = 8;  // per master
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);

	localparam int BLOCK_WORDS = 4;  // words per write op

	typedef logic [DATA_W-1:0] word_t;
	typedef logic [ADDR_W-1:0] addr_t;

endpackage

`default_nettype wire
